//--- common/race_pkg.sv
package race_pkg;

    // word widths
    localparam int ANG_WIDTH   = 9;
    localparam int MAP_H_WIDTH = 12;
    localparam int MAP_V_WIDTH = 11;
    localparam int SPD_WIDTH   = 6;
    localparam int CNT_WIDTH   = 8;

    // map limits, x in [-750, 750) and y in [-350, 350)
    localparam logic signed [MAP_H_WIDTH-1:0] MAP_H_HALF = 12'sd750;
    localparam logic signed [MAP_V_WIDTH-1:0] MAP_V_HALF = 11'sd350;

    // heading in degrees, kept in [-180, 180)
    localparam logic signed [ANG_WIDTH-1:0] ANG_HALF  = 9'sd180;
    localparam logic signed [ANG_WIDTH-1:0] TURN_STEP = 9'sd6;

    // largest heading that still rounds down into each 45 degree sector
    localparam logic signed [ANG_WIDTH-1:0] SECT_B1 = 9'sd22;
    localparam logic signed [ANG_WIDTH-1:0] SECT_B2 = 9'sd67;
    localparam logic signed [ANG_WIDTH-1:0] SECT_B3 = 9'sd112;
    localparam logic signed [ANG_WIDTH-1:0] SECT_B4 = 9'sd157;

    // speed table, per frame
    localparam logic signed [SPD_WIDTH-1:0] SPEED_AXIS = 6'sd25;
    // roughly 25 / sqrt(2) on each axis
    localparam logic signed [SPD_WIDTH-1:0] SPEED_DIAG = 6'sd18;

    // contact box half extents, one bit wider than the coordinates
    localparam logic signed [MAP_H_WIDTH:0] HIT_X = 13'sd60;
    localparam logic signed [MAP_V_WIDTH:0] HIT_Y = 12'sd40;

    // steering codes, code 3 behaves as hold
    localparam logic [1:0] STEER_HOLD  = 2'd0;
    localparam logic [1:0] STEER_LEFT  = 2'd1;
    localparam logic [1:0] STEER_RIGHT = 2'd2;

    // reset placements
    localparam logic signed [MAP_H_WIDTH-1:0] CAR1_X0 = -12'sd750;
    localparam logic signed [MAP_V_WIDTH-1:0] CAR1_Y0 = 11'sd200;
    localparam logic signed [MAP_H_WIDTH-1:0] CAR2_X0 = 12'sd750;
    localparam logic signed [MAP_V_WIDTH-1:0] CAR2_Y0 = -11'sd200;

endpackage

//--- car_motion/car_motion.sv
`timescale 1ns/10ps

module car_motion #(
    parameter logic signed [race_pkg::MAP_H_WIDTH-1:0] P_X0 = race_pkg::CAR1_X0,
    parameter logic signed [race_pkg::MAP_V_WIDTH-1:0] P_Y0 = race_pkg::CAR1_Y0
) (
    input  logic                                    i_render_clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_frame,
    input  logic [1:0]                              i_steer,
    input  logic                                    i_throttle,
    output logic signed [race_pkg::ANG_WIDTH-1:0]   o_angle,
    output logic signed [race_pkg::MAP_H_WIDTH-1:0] o_x,
    output logic signed [race_pkg::MAP_V_WIDTH-1:0] o_y
);

    logic signed [race_pkg::ANG_WIDTH-1:0]   angle_r;
    logic signed [race_pkg::ANG_WIDTH-1:0]   angle_w;
    logic signed [race_pkg::MAP_H_WIDTH-1:0] x_r;
    logic signed [race_pkg::MAP_H_WIDTH-1:0] x_w;
    logic signed [race_pkg::MAP_V_WIDTH-1:0] y_r;
    logic signed [race_pkg::MAP_V_WIDTH-1:0] y_w;
    logic [2:0]                              sector;
    logic signed [race_pkg::SPD_WIDTH-1:0]   vx;
    logic signed [race_pkg::SPD_WIDTH-1:0]   vy;

    assign o_angle = angle_r;
    assign o_x     = x_r;
    assign o_y     = y_r;

    // heading update with wrap
    always_comb begin
        case (i_steer)
            race_pkg::STEER_LEFT:  angle_w = angle_r + race_pkg::TURN_STEP;
            race_pkg::STEER_RIGHT: angle_w = angle_r - race_pkg::TURN_STEP;
            default:               angle_w = angle_r;
        endcase
        // low edge checked first, so -180 comes back to -180
        if (angle_w <= -race_pkg::ANG_HALF) begin
            angle_w = angle_w + race_pkg::ANG_HALF + race_pkg::ANG_HALF;
        end
        if (angle_w >= race_pkg::ANG_HALF) begin
            angle_w = angle_w - race_pkg::ANG_HALF - race_pkg::ANG_HALF;
        end
    end

    // nearest compass sector of the current heading, 0 = +x, 2 = +y
    always_comb begin
        if (angle_r > race_pkg::SECT_B4 || angle_r < -race_pkg::SECT_B4) begin
            sector = 3'd4;
        end else if (angle_r > race_pkg::SECT_B3) begin
            sector = 3'd3;
        end else if (angle_r > race_pkg::SECT_B2) begin
            sector = 3'd2;
        end else if (angle_r > race_pkg::SECT_B1) begin
            sector = 3'd1;
        end else if (angle_r >= -race_pkg::SECT_B1) begin
            sector = 3'd0;
        end else if (angle_r >= -race_pkg::SECT_B2) begin
            sector = 3'd7;
        end else if (angle_r >= -race_pkg::SECT_B3) begin
            sector = 3'd6;
        end else begin
            sector = 3'd5;
        end
    end

    // sector velocity
    always_comb begin
        case (sector)
            3'd0: begin vx = race_pkg::SPEED_AXIS;  vy = '0;                    end
            3'd1: begin vx = race_pkg::SPEED_DIAG;  vy = race_pkg::SPEED_DIAG;  end
            3'd2: begin vx = '0;                    vy = race_pkg::SPEED_AXIS;  end
            3'd3: begin vx = -race_pkg::SPEED_DIAG; vy = race_pkg::SPEED_DIAG;  end
            3'd4: begin vx = -race_pkg::SPEED_AXIS; vy = '0;                    end
            3'd5: begin vx = -race_pkg::SPEED_DIAG; vy = -race_pkg::SPEED_DIAG; end
            3'd6: begin vx = '0;                    vy = -race_pkg::SPEED_AXIS; end
            default: begin vx = race_pkg::SPEED_DIAG; vy = -race_pkg::SPEED_DIAG; end
        endcase
    end

    // position step with edge wrap
    always_comb begin
        x_w = x_r + $signed({{(race_pkg::MAP_H_WIDTH-race_pkg::SPD_WIDTH){vx[race_pkg::SPD_WIDTH-1]}},
                             vx});
        y_w = y_r + $signed({{(race_pkg::MAP_V_WIDTH-race_pkg::SPD_WIDTH){vy[race_pkg::SPD_WIDTH-1]}},
                             vy});
        if (x_w <= -race_pkg::MAP_H_HALF) begin
            x_w = x_w + race_pkg::MAP_H_HALF + race_pkg::MAP_H_HALF;
        end
        if (x_w >= race_pkg::MAP_H_HALF) begin
            x_w = x_w - race_pkg::MAP_H_HALF - race_pkg::MAP_H_HALF;
        end
        if (y_w <= -race_pkg::MAP_V_HALF) begin
            y_w = y_w + race_pkg::MAP_V_HALF + race_pkg::MAP_V_HALF;
        end
        if (y_w >= race_pkg::MAP_V_HALF) begin
            y_w = y_w - race_pkg::MAP_V_HALF - race_pkg::MAP_V_HALF;
        end
    end

    always_ff @(posedge i_render_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            angle_r <= '0;
            x_r     <= P_X0;
            y_r     <= P_Y0;
        end else if (i_frame) begin
            angle_r <= angle_w;
            // car only moves on throttle
            if (i_throttle) begin
                x_r <= x_w;
                y_r <= y_w;
            end
        end
    end

    a_angle_range: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        angle_r >= -race_pkg::ANG_HALF && angle_r < race_pkg::ANG_HALF);

    // checked after each move, a reset placement may sit on the edge
    a_x_range: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        (i_frame && i_throttle) |=> (x_r >= -race_pkg::MAP_H_HALF && x_r < race_pkg::MAP_H_HALF));

    a_y_range: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        (i_frame && i_throttle) |=> (y_r >= -race_pkg::MAP_V_HALF && y_r < race_pkg::MAP_V_HALF));

    a_hold: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        !i_frame |=> ($stable(angle_r) && $stable(x_r) && $stable(y_r)));

endmodule

//--- hdl/car_contact.sv
`timescale 1ns/10ps

module car_contact (
    input  logic                                    i_render_clk,
    input  logic                                    i_rst_n,
    input  logic signed [race_pkg::MAP_H_WIDTH-1:0] i_car1_x,
    input  logic signed [race_pkg::MAP_V_WIDTH-1:0] i_car1_y,
    input  logic signed [race_pkg::MAP_H_WIDTH-1:0] i_car2_x,
    input  logic signed [race_pkg::MAP_V_WIDTH-1:0] i_car2_y,
    output logic                                    o_contact,
    output logic [race_pkg::CNT_WIDTH-1:0]          o_contact_cnt
);

    logic signed [race_pkg::MAP_H_WIDTH:0] dx;
    logic signed [race_pkg::MAP_H_WIDTH:0] adx;
    logic signed [race_pkg::MAP_V_WIDTH:0] dy;
    logic signed [race_pkg::MAP_V_WIDTH:0] ady;
    logic                                  hit;
    logic                                  contact_r;
    logic [race_pkg::CNT_WIDTH-1:0]        cnt_r;

    assign o_contact     = contact_r;
    assign o_contact_cnt = cnt_r;

    // differences one bit wider, map corners are 1500 apart in x
    always_comb begin
        dx = $signed({i_car1_x[race_pkg::MAP_H_WIDTH-1], i_car1_x})
           - $signed({i_car2_x[race_pkg::MAP_H_WIDTH-1], i_car2_x});
        dy = $signed({i_car1_y[race_pkg::MAP_V_WIDTH-1], i_car1_y})
           - $signed({i_car2_y[race_pkg::MAP_V_WIDTH-1], i_car2_y});
        adx = dx[race_pkg::MAP_H_WIDTH] ? -dx : dx;
        ady = dy[race_pkg::MAP_V_WIDTH] ? -dy : dy;
    end

    // plain distance, no wrap across the map edge
    assign hit = (adx < race_pkg::HIT_X) && (ady < race_pkg::HIT_Y);

    always_ff @(posedge i_render_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            contact_r <= 1'b0;
            cnt_r     <= '0;
        end else begin
            contact_r <= hit;
            // count rising edges, stop at full scale
            if (hit && !contact_r && cnt_r != '1) begin
                cnt_r <= cnt_r + 1'b1;
            end
        end
    end

    a_cnt_monotonic: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        o_contact_cnt >= $past(o_contact_cnt));

endmodule

//--- hdl/game_control.sv
`timescale 1ns/10ps

module game_control (
    input  logic                                    i_render_clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_frame,
    input  logic [1:0]                              i_car1_steer,
    input  logic [1:0]                              i_car2_steer,
    input  logic                                    i_car1_throttle,
    input  logic                                    i_car2_throttle,
    output logic signed [race_pkg::ANG_WIDTH-1:0]   o_car1_angle,
    output logic signed [race_pkg::MAP_H_WIDTH-1:0] o_car1_x,
    output logic signed [race_pkg::MAP_V_WIDTH-1:0] o_car1_y,
    output logic signed [race_pkg::ANG_WIDTH-1:0]   o_car2_angle,
    output logic signed [race_pkg::MAP_H_WIDTH-1:0] o_car2_x,
    output logic signed [race_pkg::MAP_V_WIDTH-1:0] o_car2_y,
    output logic                                    o_contact,
    output logic [race_pkg::CNT_WIDTH-1:0]          o_contact_cnt
);

    // both cars share the frame strobe and step in the same cycle
    car_motion #(
        .P_X0 (race_pkg::CAR1_X0),
        .P_Y0 (race_pkg::CAR1_Y0)
    ) u_car1 (
        .i_render_clk (i_render_clk),
        .i_rst_n      (i_rst_n),
        .i_frame      (i_frame),
        .i_steer      (i_car1_steer),
        .i_throttle   (i_car1_throttle),
        .o_angle      (o_car1_angle),
        .o_x          (o_car1_x),
        .o_y          (o_car1_y)
    );

    car_motion #(
        .P_X0 (race_pkg::CAR2_X0),
        .P_Y0 (race_pkg::CAR2_Y0)
    ) u_car2 (
        .i_render_clk (i_render_clk),
        .i_rst_n      (i_rst_n),
        .i_frame      (i_frame),
        .i_steer      (i_car2_steer),
        .i_throttle   (i_car2_throttle),
        .o_angle      (o_car2_angle),
        .o_x          (o_car2_x),
        .o_y          (o_car2_y)
    );

    // contact check sees the registered positions, one cycle behind
    car_contact u_contact (
        .i_render_clk  (i_render_clk),
        .i_rst_n       (i_rst_n),
        .i_car1_x      (o_car1_x),
        .i_car1_y      (o_car1_y),
        .i_car2_x      (o_car2_x),
        .i_car2_y      (o_car2_y),
        .o_contact     (o_contact),
        .o_contact_cnt (o_contact_cnt)
    );

endmodule

//--- verification/race_model.svh
`ifndef RACE_MODEL_SVH
`define RACE_MODEL_SVH

// reference model of the car and contact rules, worked in plain integers

// one wrap rule serves the heading and both coordinates
function automatic int wrap_range(input int v, input int half);
    int r;
    r = v;
    if (r <= -half) begin
        r = r + 2 * half;
    end
    if (r >= half) begin
        r = r - 2 * half;
    end
    return r;
endfunction

function automatic int next_heading(input int a, input logic [1:0] steer);
    int r;
    r = a;
    if (steer == race_pkg::STEER_LEFT) begin
        r = a + int'(race_pkg::TURN_STEP);
    end else if (steer == race_pkg::STEER_RIGHT) begin
        r = a - int'(race_pkg::TURN_STEP);
    end
    return wrap_range(r, int'(race_pkg::ANG_HALF));
endfunction

// nearest 45 degree sector, offset by a full turn plus half a sector
function automatic int sector_of(input int a);
    return ((a + 360 + 22) / 45) % 8;
endfunction

// x component of the sector step, y is the same table turned by 90 degrees
function automatic int axis_step(input int s);
    case (s)
        0:       return int'(race_pkg::SPEED_AXIS);
        1, 7:    return int'(race_pkg::SPEED_DIAG);
        2, 6:    return 0;
        3, 5:    return -int'(race_pkg::SPEED_DIAG);
        default: return -int'(race_pkg::SPEED_AXIS);
    endcase
endfunction

function automatic int next_x(input int x, input int a);
    return wrap_range(x + axis_step(sector_of(a)), int'(race_pkg::MAP_H_HALF));
endfunction

function automatic int next_y(input int y, input int a);
    return wrap_range(y + axis_step((sector_of(a) + 6) % 8), int'(race_pkg::MAP_V_HALF));
endfunction

function automatic bit contact_rule(input int x1, input int y1, input int x2, input int y2);
    int dx;
    int dy;
    dx = (x1 > x2) ? x1 - x2 : x2 - x1;
    dy = (y1 > y2) ? y1 - y2 : y2 - y1;
    return (dx < int'(race_pkg::HIT_X)) && (dy < int'(race_pkg::HIT_Y));
endfunction

`endif

//--- verification/game_control_tb.sv
`timescale 1ns/10ps

module game_control_tb;

    `include "race_model.svh"

    localparam int RESET_CYCLES = 4;
    localparam int RAND_FRAMES  = 400;
    localparam int TURN_FRAMES  = 75;
    localparam int LAP_FRAMES   = 28;
    localparam int CONTACT_LAPS = 260;
    localparam int CNT_MAX      = (1 << race_pkg::CNT_WIDTH) - 1;
    localparam int RUN_CYCLES   = 2 * RESET_CYCLES + 1 + RAND_FRAMES + TURN_FRAMES + 1
                                + LAP_FRAMES * CONTACT_LAPS + 3;
    localparam logic [31:0] LFSR_SEED = 32'd87451;

    logic                                    i_render_clk;
    logic                                    i_rst_n;
    logic                                    i_frame;
    logic [1:0]                              i_car1_steer;
    logic [1:0]                              i_car2_steer;
    logic                                    i_car1_throttle;
    logic                                    i_car2_throttle;
    logic signed [race_pkg::ANG_WIDTH-1:0]   o_car1_angle;
    logic signed [race_pkg::MAP_H_WIDTH-1:0] o_car1_x;
    logic signed [race_pkg::MAP_V_WIDTH-1:0] o_car1_y;
    logic signed [race_pkg::ANG_WIDTH-1:0]   o_car2_angle;
    logic signed [race_pkg::MAP_H_WIDTH-1:0] o_car2_x;
    logic signed [race_pkg::MAP_V_WIDTH-1:0] o_car2_y;
    logic                                    o_contact;
    logic [race_pkg::CNT_WIDTH-1:0]          o_contact_cnt;

    logic [31:0] lfsr;
    logic [7:0]  bits;
    int          n;
    // shadow state of both cars and the contact logic
    int          exp_a1;
    int          exp_x1;
    int          exp_y1;
    int          exp_a2;
    int          exp_x2;
    int          exp_y2;
    bit          exp_contact;
    int          exp_cnt;

    game_control UUT (
        .i_render_clk    (i_render_clk),
        .i_rst_n         (i_rst_n),
        .i_frame         (i_frame),
        .i_car1_steer    (i_car1_steer),
        .i_car2_steer    (i_car2_steer),
        .i_car1_throttle (i_car1_throttle),
        .i_car2_throttle (i_car2_throttle),
        .o_car1_angle    (o_car1_angle),
        .o_car1_x        (o_car1_x),
        .o_car1_y        (o_car1_y),
        .o_car2_angle    (o_car2_angle),
        .o_car2_x        (o_car2_x),
        .o_car2_y        (o_car2_y),
        .o_contact       (o_contact),
        .o_contact_cnt   (o_contact_cnt)
    );

    initial i_render_clk = 1'b0;
    always #50 i_render_clk = ~i_render_clk;

    // galois form, maximal length 32 bit polynomial
    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < count; i++) begin
            v[i] = lfsr[0];
            lfsr = step_lfsr(lfsr);
        end
    endtask

    task automatic drive_inputs(input logic f, input logic [1:0] s1, input logic [1:0] s2,
                                input logic t1, input logic t2);
        @(posedge i_render_clk);
        i_frame         <= f;
        i_car1_steer    <= s1;
        i_car2_steer    <= s2;
        i_car1_throttle <= t1;
        i_car2_throttle <= t2;
    endtask

    task automatic apply_reset();
        @(posedge i_render_clk);
        i_rst_n <= 1'b0;
        i_frame <= 1'b0;
        repeat (RESET_CYCLES) @(posedge i_render_clk);
        i_rst_n <= 1'b1;
    endtask

    task automatic report_mismatch(input string what);
        $display("Mismatch at %0t ns: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    // shadow state steps on the same edge that the DUT consumes a frame
    always @(posedge i_render_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            exp_a1      <= 0;
            exp_x1      <= int'(race_pkg::CAR1_X0);
            exp_y1      <= int'(race_pkg::CAR1_Y0);
            exp_a2      <= 0;
            exp_x2      <= int'(race_pkg::CAR2_X0);
            exp_y2      <= int'(race_pkg::CAR2_Y0);
            exp_contact <= 1'b0;
            exp_cnt     <= 0;
        end else begin
            if (i_frame) begin
                exp_a1 <= next_heading(exp_a1, i_car1_steer);
                exp_a2 <= next_heading(exp_a2, i_car2_steer);
                if (i_car1_throttle) begin
                    exp_x1 <= next_x(exp_x1, exp_a1);
                    exp_y1 <= next_y(exp_y1, exp_a1);
                end
                if (i_car2_throttle) begin
                    exp_x2 <= next_x(exp_x2, exp_a2);
                    exp_y2 <= next_y(exp_y2, exp_a2);
                end
            end
            exp_contact <= contact_rule(exp_x1, exp_y1, exp_x2, exp_y2);
            if (contact_rule(exp_x1, exp_y1, exp_x2, exp_y2) && !exp_contact
                    && exp_cnt < CNT_MAX) begin
                exp_cnt <= exp_cnt + 1;
            end
        end
    end

    a_reset_state: assert property (@(posedge i_render_clk) $rose(i_rst_n) |->
        (int'(o_car1_x) == -750 && int'(o_car1_y) == 200 && int'(o_car1_angle) == 0
         && int'(o_car2_x) == 750 && int'(o_car2_y) == -200 && int'(o_car2_angle) == 0
         && !o_contact && o_contact_cnt == '0))
        else report_mismatch("car placement or contact outputs wrong after reset");

    a_heading: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        $past(i_frame) |-> (int'(o_car1_angle) == exp_a1 && int'(o_car2_angle) == exp_a2))
        else report_mismatch("car heading differs from model");

    a_position: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        $past(i_frame) |-> (int'(o_car1_x) == exp_x1 && int'(o_car1_y) == exp_y1
                            && int'(o_car2_x) == exp_x2 && int'(o_car2_y) == exp_y2))
        else report_mismatch("car position differs from model");

    a_hold: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        !$past(i_frame) |-> ($stable(o_car1_angle) && $stable(o_car1_x) && $stable(o_car1_y)
                             && $stable(o_car2_angle) && $stable(o_car2_x)
                             && $stable(o_car2_y)))
        else report_mismatch("car outputs changed without a frame");

    a_contact: assert property (@(posedge i_render_clk) disable iff (!i_rst_n)
        o_contact == exp_contact && int'(o_contact_cnt) == exp_cnt)
        else report_mismatch("contact level or contact count differs from model");

    initial begin
        #(RUN_CYCLES * 120);
        $display("Watchdog expired before the test sequence finished");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        lfsr            = LFSR_SEED;
        i_rst_n         <= 1'b0;
        i_frame         <= 1'b0;
        i_car1_steer    <= race_pkg::STEER_HOLD;
        i_car2_steer    <= race_pkg::STEER_HOLD;
        i_car1_throttle <= 1'b0;
        i_car2_throttle <= 1'b0;
        repeat (RESET_CYCLES) @(posedge i_render_clk);
        i_rst_n <= 1'b1;

        // random frames, steering and throttle
        repeat (RAND_FRAMES) begin
            draw_bits(7, bits);
            drive_inputs(bits[0], bits[2:1], bits[4:3], bits[5], bits[6]);
        end

        // both cars turn through the 180 degree seam, car1 ends at -90
        apply_reset();
        for (n = 0; n < TURN_FRAMES; n++) begin
            drive_inputs(1'b1, race_pkg::STEER_RIGHT,
                         (n < 60) ? race_pkg::STEER_LEFT : race_pkg::STEER_HOLD, 1'b0, 1'b0);
        end
        // car2 wraps across the right edge next to car1
        drive_inputs(1'b1, race_pkg::STEER_HOLD, race_pkg::STEER_HOLD, 1'b0, 1'b1);
        // car1 laps the y range and passes car2 once per lap
        repeat (LAP_FRAMES * CONTACT_LAPS) begin
            drive_inputs(1'b1, race_pkg::STEER_HOLD, race_pkg::STEER_HOLD, 1'b1, 1'b0);
        end
        repeat (3) drive_inputs(1'b0, race_pkg::STEER_HOLD, race_pkg::STEER_HOLD, 1'b0, 1'b0);

        if (exp_cnt != CNT_MAX) begin
            $display("Contact counter never saturated, only %0d contacts seen", exp_cnt);
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+verification
common/race_pkg.sv
car_motion/car_motion.sv
hdl/car_contact.sv
hdl/game_control.sv
verification/game_control_tb.sv

//--- Makefile
# Verilator build and run for the racing game core

LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal \
		-f project.f --top-module game_control_tb -o game_control_sim
	./obj_dir/game_control_sim | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall \
		common/race_pkg.sv \
		car_motion/car_motion.sv \
		hdl/car_contact.sv \
		hdl/game_control.sv \
		--top-module game_control

clean:
	rm -rf obj_dir $(LOG)
